// ==== source/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath widths
`define WORD_WIDTH 32
`define TAG_WIDTH 4

//////////////////////////////////////////////////////////////////////
// fixed unit latencies, counted in clock edges from acceptance
//////////////////////////////////////////////////////////////////////

`define ALU_LATENCY 1
`define SHIFT_LATENCY 2
`define MUL_LATENCY 4

// one reservation slot per cycle of the longest unit
`define BUS_DEPTH `MUL_LATENCY

`endif

// ==== source/exec_pkg.sv ====
`include "exec_settings.svh"

package exec_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`TAG_WIDTH-1:0] tag_t;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_MUL
	} op_t;

	typedef enum logic [1:0] {
		UNIT_ALU,
		UNIT_SHIFT,
		UNIT_MUL
	} unit_t;

	typedef struct packed {
		op_t op;
		tag_t tag;
		word_t a;
		word_t b;
	} issue_t;

	// broadcast result
	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t data;
	} cdb_t;

	function automatic unit_t unit_of(op_t op);
		case (op)
			OP_SLL, OP_SRL, OP_SRA: return UNIT_SHIFT;
			OP_MUL: return UNIT_MUL;
			default: return UNIT_ALU;
		endcase
	endfunction

endpackage

// ==== source/cdb_scheduler.sv ====
`include "exec_settings.svh"

module cdb_scheduler (
	input logic clk,
	input logic reset,
	input exec_pkg::issue_t issue,
	input logic issue_valid,
	output logic issue_ready,
	output logic start_alu,
	output logic start_shift,
	output logic start_mul,
	input exec_pkg::word_t alu_result,
	input exec_pkg::word_t shift_result,
	input exec_pkg::word_t mul_result,
	output exec_pkg::cdb_t cdb
);
	import exec_pkg::*;

	localparam int SLOT_WIDTH = $clog2(`BUS_DEPTH);

	typedef struct packed {
		tag_t tag;
		unit_t unit;
	} slot_info_t;

	// slot k reaches the bus k cycles from now
	logic [`BUS_DEPTH-1:0] slot_valid;
	slot_info_t slot_info [`BUS_DEPTH];

	unit_t issue_unit;
	logic accept;
	logic [SLOT_WIDTH-1:0] write_slot;
	word_t bus_data;

	logic bus_valid;
	tag_t bus_tag;
	word_t bus_word;

	//////////////////////////////////////////////////////////////////////
	// issue side
	//////////////////////////////////////////////////////////////////////

	assign issue_unit = unit_of(issue.op);

	// longest unit wins, shorter ones check the slot they would land in
	always_comb begin
		case (issue_unit)
			UNIT_ALU: begin
				issue_ready = !slot_valid[`ALU_LATENCY];
				write_slot = SLOT_WIDTH'(`ALU_LATENCY - 1);
			end
			UNIT_SHIFT: begin
				issue_ready = !slot_valid[`SHIFT_LATENCY];
				write_slot = SLOT_WIDTH'(`SHIFT_LATENCY - 1);
			end
			default: begin
				issue_ready = 1'b1;
				write_slot = SLOT_WIDTH'(`MUL_LATENCY - 1);
			end
		endcase
	end

	assign accept = issue_valid && issue_ready;
	assign start_alu = accept && issue_unit == UNIT_ALU;
	assign start_shift = accept && issue_unit == UNIT_SHIFT;
	assign start_mul = accept && issue_unit == UNIT_MUL;

	//////////////////////////////////////////////////////////////////////
	// reservation chain
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= '0;
		end else begin
			slot_valid <= slot_valid >> 1;
			if (accept) begin
				slot_valid[write_slot] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `BUS_DEPTH - 1; i++) begin
			slot_info[i] <= slot_info[i+1];
		end
		if (accept) begin
			slot_info[write_slot] <= '{tag: issue.tag, unit: issue_unit};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// broadcast
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (slot_info[0].unit)
			UNIT_ALU: bus_data = alu_result;
			UNIT_SHIFT: bus_data = shift_result;
			default: bus_data = mul_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bus_valid <= 1'b0;
		end else begin
			bus_valid <= slot_valid[0];
		end
	end

	always_ff @(posedge clk) begin
		bus_tag <= slot_info[0].tag;
		bus_word <= bus_data;
	end

	assign cdb = '{valid: bus_valid, tag: bus_tag, data: bus_word};

endmodule

// ==== source/alu_unit.sv ====
module alu_unit (
	input logic clk,
	input logic start,
	input exec_pkg::op_t op,
	input exec_pkg::word_t a,
	input exec_pkg::word_t b,
	output exec_pkg::word_t result
);
	import exec_pkg::*;

	word_t value;

	// add/logic ops, anything else falls back to add
	always_comb begin
		case (op)
			OP_ADD: begin
				value = a + b;
			end
			OP_SUB: begin
				value = a - b;
			end
			OP_AND: begin
				value = a & b;
			end
			OP_OR: begin
				value = a | b;
			end
			OP_XOR: begin
				value = a ^ b;
			end
			default: begin
				value = a + b;
			end
		endcase
	end

	// held until the next alu op, the bus reads it one edge later
	always_ff @(posedge clk) begin
		if (start) begin
			result <= value;
		end
	end

endmodule

// ==== source/shift_unit.sv ====
`include "exec_settings.svh"

module shift_unit (
	input logic clk,
	input logic start,
	input exec_pkg::op_t op,
	input exec_pkg::word_t a,
	input exec_pkg::word_t b,
	output exec_pkg::word_t result
);
	import exec_pkg::*;

	localparam int AMOUNT_WIDTH = $clog2(`WORD_WIDTH);

	// stage 1 registers
	word_t operand_q;
	op_t kind_q;
	logic [AMOUNT_WIDTH-1:0] amount_q;

	word_t shifted;

	//////////////////////////////////////////////////////////////////////
	// stage 1, capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start) begin
			operand_q <= a;
			kind_q <= op;
			amount_q <= b[AMOUNT_WIDTH-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stage 2, shift
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (kind_q)
			OP_SLL: begin
				shifted = operand_q << amount_q;
			end
			OP_SRL: begin
				shifted = operand_q >> amount_q;
			end
			default: begin
				// sign fill
				shifted = $signed(operand_q) >>> amount_q;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		result <= shifted;
	end

endmodule

// ==== source/mul_unit.sv ====
`include "exec_settings.svh"

module mul_unit (
	input logic clk,
	input exec_pkg::word_t a,
	input exec_pkg::word_t b,
	output exec_pkg::word_t result
);
	import exec_pkg::*;

	localparam int STAGES = `MUL_LATENCY;
	localparam int SLICE = `WORD_WIDTH / STAGES;

	// operands travel with the running sum, last stage needs none
	word_t a_q [STAGES-1];
	word_t b_q [STAGES-1];
	word_t sum_q [STAGES];

	// one slice of b times a, moved to its weight
	function automatic word_t partial(word_t x, word_t y, int stage);
		logic [SLICE-1:0] slice;
		word_t wide_slice;
		slice = y[stage*SLICE +: SLICE];
		wide_slice = word_t'(slice);
		return (x * wide_slice) << (stage * SLICE);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// first stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		a_q[0] <= a;
		b_q[0] <= b;
		sum_q[0] <= partial(a, b, 0);
	end

	//////////////////////////////////////////////////////////////////////
	// remaining stages
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int s = 1; s < STAGES; s++) begin
			sum_q[s] <= sum_q[s-1] + partial(a_q[s-1], b_q[s-1], s);
		end
		for (int s = 1; s < STAGES - 1; s++) begin
			a_q[s] <= a_q[s-1];
			b_q[s] <= b_q[s-1];
		end
	end

	// low word of the product
	assign result = sum_q[STAGES-1];

endmodule

// ==== source/exec_cluster.sv ====
module exec_cluster (
	input logic clk,
	input logic reset,
	input exec_pkg::issue_t issue,
	input logic issue_valid,
	output logic issue_ready,
	output exec_pkg::cdb_t cdb
);

	logic start_alu;
	logic start_shift;
	logic start_mul;
	exec_pkg::word_t alu_result;
	exec_pkg::word_t shift_result;
	exec_pkg::word_t mul_result;

	cdb_scheduler scheduler (
		.clk,
		.reset,
		.issue,
		.issue_valid,
		.issue_ready,
		.start_alu,
		.start_shift,
		.start_mul,
		.alu_result,
		.shift_result,
		.mul_result,
		.cdb
	);

	// units see every issue, only their start pulse matters
	alu_unit alu (
		.clk,
		.start(start_alu),
		.op(issue.op),
		.a(issue.a),
		.b(issue.b),
		.result(alu_result)
	);

	shift_unit shifter (
		.clk,
		.start(start_shift),
		.op(issue.op),
		.a(issue.a),
		.b(issue.b),
		.result(shift_result)
	);

	// free running, read only when a reservation points at it
	mul_unit mul (
		.clk,
		.a(issue.a),
		.b(issue.b),
		.result(mul_result)
	);

endmodule

// ==== sim/exec_cluster_tb.sv ====
`include "exec_settings.svh"

module exec_cluster_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import exec_pkg::*;

	localparam int STALL_LIMIT = 16;
	localparam int DRAIN_LIMIT = 32;
	localparam int RANDOM_COUNT = 200;

	// one issued operation, stalls of -1 are not checked
	typedef struct {
		op_t op;
		word_t a;
		word_t b;
		tag_t tag;
		int idle;
		int stalls;
	} entry_t;

	typedef struct {
		tag_t tag;
		word_t data;
		int due;
	} result_t;

	logic clk;
	logic reset;
	issue_t issue;
	logic issue_valid;
	logic issue_ready;
	cdb_t cdb;

	entry_t stimulus[$];
	result_t pending[$];
	int edge_count = 0;
	logic [31:0] rand_state = 32'h6000f37f;

	exec_cluster DUT (
		.clk,
		.reset,
		.issue,
		.issue_valid,
		.issue_ready,
		.cdb
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		edge_count <= edge_count + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// checks and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
			$display("Test failures found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic abort_run(input string what);
		$display("Error: %s", what);
		$display("Test failures found");
		$fatal(1, "%s", what);
	endtask

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic word_t expected_result(op_t op, word_t a, word_t b);
		logic [63:0] product;
		logic [4:0] amount;
		amount = b[4:0];
		product = {32'd0, a} * {32'd0, b};
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a + ~b + 32'd1;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_SLL: return a << amount;
			OP_SRL: return a >> amount;
			// negative values shift in ones
			OP_SRA: return a[31] ? ~((~a) >> amount) : a >> amount;
			OP_MUL: return product[31:0];
			default: return '0;
		endcase
	endfunction

	function automatic int latency_of(op_t op);
		case (op)
			OP_SLL, OP_SRL, OP_SRA: return `SHIFT_LATENCY;
			OP_MUL: return `MUL_LATENCY;
			default: return `ALU_LATENCY;
		endcase
	endfunction

	// one bus cycle at a time, matched against the due edge
	always @(negedge clk) begin : bus_monitor
		int hit;
		hit = -1;
		foreach (pending[i]) begin
			if (pending[i].due == edge_count) begin
				hit = i;
			end
		end
		check("cdb.valid", 32'(cdb.valid), 32'(hit >= 0));
		if (hit >= 0) begin
			check("cdb.tag", 32'(cdb.tag), 32'(pending[hit].tag));
			check("cdb.data", cdb.data, pending[hit].data);
			pending.delete(hit);
		end
		// in-flight work is lost on reset
		if (reset) begin
			pending.delete();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	function automatic void add_entry(op_t op, word_t a, word_t b, int idle, int stalls);
		entry_t e;
		e.op = op;
		e.a = a;
		e.b = b;
		e.tag = tag_t'(stimulus.size() % 16);
		e.idle = idle;
		e.stalls = stalls;
		stimulus.push_back(e);
	endfunction

	function automatic void load_directed();
		add_entry(OP_ADD, 32'd1, 32'd2, 0, 0);
		add_entry(OP_ADD, 32'hffffffff, 32'd1, 0, 0);
		add_entry(OP_ADD, 32'h7fffffff, 32'd1, 0, 0);
		add_entry(OP_SUB, 32'd5, 32'd7, 0, 0);
		add_entry(OP_SUB, 32'h80000000, 32'd1, 0, 0);
		add_entry(OP_AND, 32'hf0f0f0f0, 32'hff00ff00, 0, 0);
		add_entry(OP_OR, 32'hf0f0f0f0, 32'h0f0f0f01, 0, 0);
		add_entry(OP_XOR, 32'hdeadbeef, 32'hffffffff, 0, 0);
		// shifts, amount from the low five bits of b
		add_entry(OP_SLL, 32'h00000001, 32'd0, 0, 0);
		add_entry(OP_SLL, 32'h00000001, 32'd31, 0, 0);
		add_entry(OP_SLL, 32'hdeadbeef, 32'd4, 0, 0);
		add_entry(OP_SRL, 32'h80000000, 32'd31, 0, 0);
		add_entry(OP_SRL, 32'hdeadbeef, 32'd0, 0, 0);
		add_entry(OP_SRL, 32'hf0f0f0f0, 32'h00000124, 0, 0);
		add_entry(OP_SRA, 32'h80000000, 32'd31, 0, 0);
		add_entry(OP_SRA, 32'hdeadbeef, 32'd4, 0, 0);
		add_entry(OP_SRA, 32'hfffffff0, 32'd0, 0, 0);
		add_entry(OP_SRA, 32'h7fffffff, 32'd31, 0, 0);
		// multiplies back to back
		add_entry(OP_MUL, 32'd6, 32'd7, 0, 0);
		add_entry(OP_MUL, 32'hffffffff, 32'hffffffff, 0, 0);
		add_entry(OP_MUL, 32'h12345678, 32'h9abcdef0, 0, 0);
		add_entry(OP_MUL, 32'h00010000, 32'h00010000, 0, 0);
		add_entry(OP_MUL, 32'hfffffffd, 32'd5, 0, 0);
		add_entry(OP_MUL, 32'd0, 32'hdeadbeef, 0, 0);
		// slot conflicts, each shorter op waits one cycle
		add_entry(OP_MUL, 32'd1000, 32'd1000, 4, 0);
		add_entry(OP_ADD, 32'd40, 32'd2, 2, 1);
		add_entry(OP_MUL, 32'habcd, 32'h1234, 4, 0);
		add_entry(OP_SRA, 32'h80000010, 32'd3, 1, 1);
	endfunction

	function automatic void load_random();
		op_t op;
		word_t a;
		word_t b;
		int idle;
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			op = op_t'(4'((next_random() >> 8) % 9));
			a = next_random();
			b = next_random();
			idle = int'((next_random() >> 12) % 4);
			add_entry(op, a, b, idle, -1);
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// driver
	//////////////////////////////////////////////////////////////////////

	task automatic expect_result(input tag_t tag, input word_t data, input int due);
		result_t r;
		foreach (pending[i]) begin
			if (pending[i].due == due) begin
				abort_run("two results expected on cdb in the same cycle");
			end
		end
		r.tag = tag;
		r.data = data;
		r.due = due;
		pending.push_back(r);
	endtask

	task automatic apply_entry(input entry_t e);
		int stalls;
		repeat (e.idle) begin
			@(posedge clk);
			issue_valid <= 1'b0;
		end
		@(posedge clk);
		issue <= '{op: e.op, tag: e.tag, a: e.a, b: e.b};
		issue_valid <= 1'b1;
		stalls = 0;
		@(negedge clk);
		while (!issue_ready) begin
			stalls++;
			if (stalls > STALL_LIMIT) begin
				abort_run("timeout waiting for issue_ready");
			end else begin
				@(negedge clk);
			end
		end
		if (e.stalls >= 0) begin
			check("issue stall cycles", stalls, e.stalls);
		end
		// accepted on the coming edge
		expect_result(e.tag, expected_result(e.op, e.a, e.b),
			edge_count + 1 + latency_of(e.op));
	endtask

	task automatic apply_from(input int first);
		for (int i = first; i < stimulus.size(); i++) begin
			apply_entry(stimulus[i]);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending.size() != 0) begin
			if (waited >= DRAIN_LIMIT) begin
				abort_run("timeout waiting for outstanding results on cdb");
			end else begin
				@(posedge clk);
				waited++;
			end
		end
	endtask

	// every op must be ready with nothing in flight
	task automatic check_idle_ready();
		for (int k = 0; k <= int'(OP_MUL); k++) begin
			@(posedge clk);
			issue_valid <= 1'b0;
			issue <= '{op: op_t'(4'(k)), tag: '0, a: '0, b: '0};
			@(negedge clk);
			check("issue_ready", 32'(issue_ready), 32'd1);
		end
	endtask

	initial begin
		int first;
		reset <= 1'b1;
		issue_valid <= 1'b0;
		issue <= '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		check_idle_ready();

		load_directed();
		load_random();
		apply_from(0);
		@(posedge clk);
		issue_valid <= 1'b0;
		wait_drain();

		// reset lands with three results still in flight
		first = stimulus.size();
		add_entry(OP_MUL, 32'd3, 32'd9, 4, 0);
		add_entry(OP_MUL, 32'h55555555, 32'd3, 0, 0);
		add_entry(OP_ADD, 32'd100, 32'd23, 0, 0);
		apply_from(first);
		@(posedge clk);
		issue_valid <= 1'b0;
		reset <= 1'b1;
		// single reset edge, both multiplies would still be due afterwards
		@(posedge clk);
		reset <= 1'b0;
		check_idle_ready();
		repeat (6) @(posedge clk);

		first = stimulus.size();
		add_entry(OP_ADD, 32'd10, 32'd20, 0, 0);
		add_entry(OP_MUL, 32'd11, 32'd13, 0, 0);
		apply_from(first);
		@(posedge clk);
		issue_valid <= 1'b0;
		wait_drain();

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+source
source/exec_pkg.sv
source/cdb_scheduler.sv
source/alu_unit.sv
source/shift_unit.sv
source/mul_unit.sv
source/exec_cluster.sv
sim/exec_cluster_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The exit status is the simulator's, non-zero on any failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module exec_cluster_tb \
	--Mdir obj_dir \
	-f list.f

./obj_dir/Vexec_cluster_tb
